// File: run.sh
#!/bin/sh
# build and run the cache memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dcache_mem -Mdir obj_dir -f vlog.f > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_dcache_mem > sim.log 2>&1 || echo "simulation exited with an error"
cat sim.log

grep -q "^Result: PASSED$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: src/dcache_geom_pkg.sv
//////////////////////////////////////////////////////////////////////
// geometry of the L1 data cache memory stage
// two ways, sixteen sets, 32-byte lines split over four 64-bit banks
//////////////////////////////////////////////////////////////////////

package dcache_geom_pkg;

  localparam int unsigned NUM_WAYS     = 2;
  localparam int unsigned NUM_BANKS    = 4;
  localparam int unsigned NUM_SETS     = 16;
  localparam int unsigned NUM_RD_PORTS = 2;

  // address fields
  localparam int unsigned TAG_W = 8;
  localparam int unsigned IDX_W = 4;
  // byte offset, the upper bits pick the bank
  localparam int unsigned OFF_W = 5;

  localparam int unsigned WORD_W    = 64;
  localparam int unsigned WORD_BE_W = WORD_W / 8;
  localparam int unsigned LINE_W    = NUM_BANKS * WORD_W;
  localparam int unsigned LINE_BE_W = LINE_W / 8;
  localparam int unsigned BANK_W    = $clog2(NUM_BANKS);
  localparam int unsigned PORT_W    = (NUM_RD_PORTS > 1) ? $clog2(NUM_RD_PORTS) : 1;

  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [IDX_W-1:0]     idx_t;
  typedef logic [OFF_W-1:0]     off_t;
  typedef logic [BANK_W-1:0]    bank_sel_t;
  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [WORD_BE_W-1:0] word_be_t;
  // one bit per way for hits, valid bits and write enables
  typedef logic [NUM_WAYS-1:0]  way_mask_t;
  typedef logic [LINE_W-1:0]    line_t;
  typedef logic [LINE_BE_W-1:0] line_be_t;
  typedef logic [PORT_W-1:0]    rd_port_sel_t;

endpackage

// File: src/dcache_mem_top.sv
//////////////////////////////////////////////////////////////////////
// memory stage of a write-through L1 data cache
// read results are valid one cycle after rd_ack_o with the tag supplied then
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_mem_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  dcache_req_pkg::rd_req_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_req_i,
  input  dcache_geom_pkg::tag_t   [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_tag_i,
  input  dcache_req_pkg::line_wr_t                                    line_wr_i,
  input  dcache_req_pkg::word_wr_t                                    word_wr_i,
  output logic                    [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_ack_o,
  output logic                                                        wr_ack_o,
  output dcache_geom_pkg::way_mask_t                                  rd_vld_bits_o,
  output dcache_geom_pkg::way_mask_t                                  rd_hit_oh_o,
  output dcache_geom_pkg::word_t                                      rd_data_o
);

  import dcache_geom_pkg::*;
  import dcache_req_pkg::*;

  bank_cmd_t [NUM_BANKS-1:0]                bank_cmd;
  word_t     [NUM_BANKS-1:0][NUM_WAYS-1:0]  bank_rdata;
  tag_cmd_t                                 tag_cmd;
  tag_t                                     lookup_tag;
  bank_sel_t                                lookup_bank;
  logic                                     cmp_en;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  dcache_port_arbiter port_arbiter_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_tag_i      (rd_tag_i),
    .line_wr_i     (line_wr_i),
    .word_wr_i     (word_wr_i),
    .rd_ack_o      (rd_ack_o),
    .wr_ack_o      (wr_ack_o),
    .bank_cmd_o    (bank_cmd),
    .tag_cmd_o     (tag_cmd),
    .lookup_tag_o  (lookup_tag),
    .lookup_bank_o (lookup_bank),
    .cmp_en_o      (cmp_en)
  );

  //////////////////////////////////////////////////////////////////////
  // data banks, bank k holds word k of the line for every way
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_data_bank
    dcache_sram #(
      .NumWays (NUM_WAYS)
    ) data_bank_i (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_cmd[k].req),
      .we_i    (bank_cmd[k].we),
      .addr_i  (bank_cmd[k].idx),
      .wdata_i (bank_cmd[k].wdata),
      .be_i    (bank_cmd[k].be),
      .rdata_o (bank_rdata[k])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // compare and result
  //////////////////////////////////////////////////////////////////////

  dcache_tag_compare tag_compare_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tag_cmd_i     (tag_cmd),
    .lookup_tag_i  (lookup_tag),
    .cmp_en_i      (cmp_en),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o)
  );

  dcache_readout readout_i (
    .bank_rdata_i  (bank_rdata),
    .lookup_bank_i (lookup_bank),
    .hit_oh_i      (rd_hit_oh_o),
    .line_wr_i     (line_wr_i),
    .rd_data_o     (rd_data_o)
  );

endmodule

// File: src/dcache_port_arbiter.sv
//////////////////////////////////////////////////////////////////////
// decode stage, grants one read per cycle and builds array commands
// a valid line write blocks all reads and word writes in its cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_port_arbiter (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  dcache_req_pkg::rd_req_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_req_i,
  input  dcache_geom_pkg::tag_t   [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_tag_i,
  input  dcache_req_pkg::line_wr_t                                    line_wr_i,
  input  dcache_req_pkg::word_wr_t                                    word_wr_i,
  output logic                    [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_ack_o,
  output logic                                                        wr_ack_o,
  output dcache_req_pkg::bank_cmd_t [dcache_geom_pkg::NUM_BANKS-1:0]  bank_cmd_o,
  output dcache_req_pkg::tag_cmd_t                                    tag_cmd_o,
  output dcache_geom_pkg::tag_t                                       lookup_tag_o,
  output dcache_geom_pkg::bank_sel_t                                  lookup_bank_o,
  output logic                                                        cmp_en_o
);

  import dcache_geom_pkg::*;
  import dcache_req_pkg::*;

  logic [NUM_RD_PORTS-1:0] req_vec;
  logic [NUM_RD_PORTS-1:0] prio_vec;
  logic [NUM_RD_PORTS-1:0] req_masked;
  logic                    gnt_found;
  logic                    rd_grant;
  logic                    collision;
  rd_port_sel_t            gnt_sel;
  rd_port_sel_t            rr_ptr_q;
  rd_port_sel_t            sel_q;
  bank_sel_t               rd_bank;
  bank_sel_t               wr_bank;
  bank_sel_t               bank_q;
  logic                    cmp_en_q;

  //////////////////////////////////////////////////////////////////////
  // read arbitration
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : gen_req_vec
    assign req_vec[p]  = rd_req_i[p].req;
    assign prio_vec[p] = rd_req_i[p].req & rd_req_i[p].prio;
  end

  // high priority requests hide the low priority ones
  assign req_masked = (|prio_vec) ? prio_vec : req_vec;

  // search starts at the round-robin pointer
  always_comb begin : p_rr_search
    int unsigned p;
    gnt_found = 1'b0;
    gnt_sel   = '0;
    for (int unsigned i = 0; i < NUM_RD_PORTS; i++) begin
      p = (int'(rr_ptr_q) + i) % NUM_RD_PORTS;
      if (!gnt_found && req_masked[p]) begin
        gnt_found = 1'b1;
        gnt_sel   = rd_port_sel_t'(p);
      end
    end
  end

  assign rd_grant = gnt_found & ~line_wr_i.vld;

  always_comb begin : p_rd_ack
    rd_ack_o = '0;
    if (rd_grant) begin
      rd_ack_o[gnt_sel] = 1'b1;
    end
  end

  // word write only waits for a read to the same bank
  assign rd_bank   = rd_req_i[gnt_sel].off[OFF_W-1 -: BANK_W];
  assign wr_bank   = word_wr_i.off[OFF_W-1 -: BANK_W];
  assign collision = rd_grant && (rd_bank == wr_bank);
  assign wr_ack_o  = (|word_wr_i.req) & ~line_wr_i.vld & ~collision;

  //////////////////////////////////////////////////////////////////////
  // array commands
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_bank_cmd
    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_cmd_o[k].req = 1'b0;
      bank_cmd_o[k].we  = 1'b0;
      bank_cmd_o[k].idx = word_wr_i.idx;
      for (int j = 0; j < NUM_WAYS; j++) begin
        bank_cmd_o[k].wdata[j] = word_wr_i.data;
        bank_cmd_o[k].be[j]    = '0;
      end
    end

    if (line_wr_i.vld) begin
      // refill touches every bank of the line
      for (int k = 0; k < NUM_BANKS; k++) begin
        bank_cmd_o[k].req = 1'b1;
        bank_cmd_o[k].we  = 1'b1;
        bank_cmd_o[k].idx = line_wr_i.idx;
        for (int j = 0; j < NUM_WAYS; j++) begin
          bank_cmd_o[k].wdata[j] = line_wr_i.data[k*WORD_W +: WORD_W];
          bank_cmd_o[k].be[j]    = line_wr_i.way_we[j] ?
                                   line_wr_i.be[k*WORD_BE_W +: WORD_BE_W] : '0;
        end
      end
    end else begin
      if (rd_grant) begin
        bank_cmd_o[rd_bank].req = 1'b1;
        bank_cmd_o[rd_bank].idx = rd_req_i[gnt_sel].idx;
      end
      if (wr_ack_o) begin
        bank_cmd_o[wr_bank].req = 1'b1;
        bank_cmd_o[wr_bank].we  = 1'b1;
        bank_cmd_o[wr_bank].idx = word_wr_i.idx;
        for (int j = 0; j < NUM_WAYS; j++) begin
          bank_cmd_o[wr_bank].be[j] = word_wr_i.req[j] ? word_wr_i.be : '0;
        end
      end
    end
  end

  // reads look up every way, refills write the enabled ways
  assign tag_cmd_o.req      = line_wr_i.vld ? line_wr_i.way_we :
                              (rd_grant ? '1 : '0);
  assign tag_cmd_o.we       = line_wr_i.vld;
  assign tag_cmd_o.idx      = line_wr_i.vld ? line_wr_i.idx : rd_req_i[gnt_sel].idx;
  assign tag_cmd_o.tag      = line_wr_i.tag;
  assign tag_cmd_o.vld_bits = line_wr_i.vld_bits;

  //////////////////////////////////////////////////////////////////////
  // lookup registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_ptr_q <= '0;
      sel_q    <= '0;
      bank_q   <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      if (rd_grant) begin
        rr_ptr_q <= (int'(gnt_sel) == NUM_RD_PORTS - 1) ? '0 : gnt_sel + 1'b1;
      end
      sel_q    <= gnt_sel;
      bank_q   <= rd_bank;
      cmp_en_q <= rd_grant;
    end
  end

  // tag of the granted port arrives one cycle after the grant
  assign lookup_tag_o  = rd_tag_i[sel_q];
  assign lookup_bank_o = bank_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

// File: src/dcache_readout.sv
//////////////////////////////////////////////////////////////////////
// result stage, purely combinational
// a miss reads as zero, a valid line write bypasses the arrays
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_readout (
  input  dcache_geom_pkg::word_t
         [dcache_geom_pkg::NUM_BANKS-1:0][dcache_geom_pkg::NUM_WAYS-1:0] bank_rdata_i,
  input  dcache_geom_pkg::bank_sel_t                                     lookup_bank_i,
  input  dcache_geom_pkg::way_mask_t                                     hit_oh_i,
  input  dcache_req_pkg::line_wr_t                                       line_wr_i,
  output dcache_geom_pkg::word_t                                         rd_data_o
);

  import dcache_geom_pkg::*;

  word_t [NUM_WAYS-1:0] way_word;
  word_t                hit_word;
  bank_sel_t            line_bank;

  // word of the looked-up bank in every way
  always_comb begin : p_way_word
    for (int j = 0; j < NUM_WAYS; j++) begin
      way_word[j] = bank_rdata_i[lookup_bank_i][j];
    end
  end

  // one-hot mux, no hit leaves zero
  always_comb begin : p_hit_mux
    hit_word = '0;
    for (int j = 0; j < NUM_WAYS; j++) begin
      if (hit_oh_i[j]) begin
        hit_word = hit_word | way_word[j];
      end
    end
  end

  assign line_bank = line_wr_i.off[OFF_W-1 -: BANK_W];

  // refill data goes straight to the output
  assign rd_data_o = line_wr_i.vld ? line_wr_i.data[line_bank*WORD_W +: WORD_W] : hit_word;

endmodule

// File: src/dcache_req_pkg.sv
//////////////////////////////////////////////////////////////////////
// request and command bundles of the cache memory stage
//////////////////////////////////////////////////////////////////////

package dcache_req_pkg;

  import dcache_geom_pkg::*;

  // one read port
  typedef struct packed {
    idx_t idx;
    off_t off;
    logic req;
    logic prio;
  } rd_req_t;

  // full line refill, writes tag and valid bits as well
  typedef struct packed {
    logic      vld;
    way_mask_t way_we;
    tag_t      tag;
    idx_t      idx;
    off_t      off;
    line_t     data;
    line_be_t  be;
    way_mask_t vld_bits;
  } line_wr_t;

  // single word store, req is one-hot over the ways
  typedef struct packed {
    way_mask_t req;
    idx_t      idx;
    off_t      off;
    word_t     data;
    word_be_t  be;
  } word_wr_t;

  // command to one data bank
  typedef struct packed {
    logic                      req;
    logic                      we;
    idx_t                      idx;
    word_t    [NUM_WAYS-1:0]   wdata;
    word_be_t [NUM_WAYS-1:0]   be;
  } bank_cmd_t;

  // command to the tag and valid arrays
  typedef struct packed {
    way_mask_t req;
    logic      we;
    idx_t      idx;
    tag_t      tag;
    way_mask_t vld_bits;
  } tag_cmd_t;

endpackage

// File: src/dcache_sram.sv
//////////////////////////////////////////////////////////////////////
// behavioral single-port RAM, one word per way at each set
// read data is registered and held until the next read request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_sram #(
  parameter int unsigned NumWays = dcache_geom_pkg::NUM_WAYS
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  dcache_geom_pkg::idx_t                   addr_i,
  input  dcache_geom_pkg::word_t    [NumWays-1:0] wdata_i,
  input  dcache_geom_pkg::word_be_t [NumWays-1:0] be_i,
  output dcache_geom_pkg::word_t    [NumWays-1:0] rdata_o
);

  import dcache_geom_pkg::*;

  word_t [NumWays-1:0] mem_q [NUM_SETS];
  word_t [NumWays-1:0] rdata_q;

  // byte-wise write into the addressed set
  always_ff @(posedge clk_i) begin : p_write
    if (req_i && we_i) begin
      for (int w = 0; w < NumWays; w++) begin
        for (int b = 0; b < WORD_BE_W; b++) begin
          if (be_i[w][b]) begin
            mem_q[addr_i][w][8*b +: 8] <= wdata_i[w][8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: src/dcache_tag_compare.sv
//////////////////////////////////////////////////////////////////////
// execute stage with the tag and valid arrays of all ways
// each way entry sits in the low bits of one RAM word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dcache_tag_compare (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  dcache_req_pkg::tag_cmd_t  tag_cmd_i,
  input  dcache_geom_pkg::tag_t     lookup_tag_i,
  input  logic                      cmp_en_i,
  output dcache_geom_pkg::way_mask_t rd_vld_bits_o,
  output dcache_geom_pkg::way_mask_t rd_hit_oh_o
);

  import dcache_geom_pkg::*;

  word_t    [NUM_WAYS-1:0] tag_wdata;
  word_be_t [NUM_WAYS-1:0] tag_be;
  word_t    [NUM_WAYS-1:0] tag_rdata;
  tag_t     [NUM_WAYS-1:0] way_tag;
  way_mask_t               way_vld;

  // entry layout is valid bit above the tag
  always_comb begin : p_wdata
    for (int i = 0; i < NUM_WAYS; i++) begin
      tag_wdata[i] = word_t'({tag_cmd_i.vld_bits[i], tag_cmd_i.tag});
      tag_be[i]    = tag_cmd_i.req[i] ? '1 : '0;
    end
  end

  dcache_sram #(
    .NumWays (NUM_WAYS)
  ) tag_sram_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (|tag_cmd_i.req),
    .we_i    (tag_cmd_i.we),
    .addr_i  (tag_cmd_i.idx),
    .wdata_i (tag_wdata),
    .be_i    (tag_be),
    .rdata_o (tag_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // hit generation
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_WAYS; i++) begin : gen_way_cmp
    assign way_tag[i] = tag_rdata[i][TAG_W-1:0];
    assign way_vld[i] = tag_rdata[i][TAG_W];

    // compare against the tag that came in one cycle after the grant
    assign rd_hit_oh_o[i] = cmp_en_i & way_vld[i] & (way_tag[i] == lookup_tag_i);
  end

  assign rd_vld_bits_o = way_vld;

endmodule

// File: tb/tb_dcache_mem.sv
//////////////////////////////////////////////////////////////////////
// testbench for the cache memory stage, checks run as assertions
// every set gets both ways line-written before any read or word write
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_dcache_mem;

  import dcache_geom_pkg::*;
  import dcache_req_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned NUM_STEPS  = 80;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  rd_req_t   [NUM_RD_PORTS-1:0]  rd_req;
  tag_t      [NUM_RD_PORTS-1:0]  rd_tag;
  line_wr_t                      line_wr;
  word_wr_t                      word_wr;
  logic      [NUM_RD_PORTS-1:0]  rd_ack;
  logic                          wr_ack;
  way_mask_t                     rd_vld_bits;
  way_mask_t                     rd_hit_oh;
  word_t                         rd_data;

  // reference model
  tag_t      ref_tag  [NUM_SETS][NUM_WAYS];
  way_mask_t ref_vld  [NUM_SETS];
  word_t     ref_word [NUM_SETS][NUM_WAYS][NUM_BANKS];
  int        rr_model;
  logic [31:0] lcg_state = 32'd8927;

  // expected values, changed only on the falling edge
  logic      chk_en, ack_chk, wack_chk, pend;
  way_mask_t exp_hit, exp_vld, pend_hit, pend_vld;
  word_t     exp_data, exp_bypass, pend_data;
  logic [NUM_RD_PORTS-1:0] exp_rd_ack;
  logic      exp_wr_ack;
  int        errors = 0;

  dcache_mem_top dcache_mem_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req),
    .rd_tag_i      (rd_tag),
    .line_wr_i     (line_wr),
    .word_wr_i     (word_wr),
    .rd_ack_o      (rd_ack),
    .wr_ack_o      (wr_ack),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_hit_oh_o   (rd_hit_oh),
    .rd_data_o     (rd_data)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
    $display("Result: FAILED");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic stop_on_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "%s", msg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(rd_ack))
    else stop_on_error("more than one rd_ack_o bit is high in the same cycle");
  a_lw_rd_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                  !line_wr.vld || rd_ack == '0)
    else report_mismatch("rd_ack_o", 64'(rd_ack), 64'h0);
  a_lw_wr_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                  !line_wr.vld || !wr_ack)
    else report_mismatch("wr_ack_o", 64'(wr_ack), 64'h0);
  a_lw_bypass: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                !line_wr.vld || rd_data == exp_bypass)
    else report_mismatch("rd_data_o", rd_data, exp_bypass);
  a_rd_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
                             !ack_chk || rd_ack == exp_rd_ack)
    else report_mismatch("rd_ack_o", 64'(rd_ack), 64'(exp_rd_ack));
  a_wr_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
                             !wack_chk || wr_ack == exp_wr_ack)
    else report_mismatch("wr_ack_o", 64'(wr_ack), 64'(exp_wr_ack));
  // without a lookup in compare the hit vector stays low
  a_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
                          rd_hit_oh == (chk_en ? exp_hit : '0))
    else report_mismatch("rd_hit_oh_o", 64'(rd_hit_oh), chk_en ? 64'(exp_hit) : 64'h0);
  a_vld: assert property (@(posedge clk_i) disable iff (!rst_ni)
                          !chk_en || rd_vld_bits == exp_vld)
    else report_mismatch("rd_vld_bits_o", 64'(rd_vld_bits), 64'(exp_vld));
  a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
                           !chk_en || rd_data == exp_data)
    else report_mismatch("rd_data_o", rd_data, exp_data);

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic word_t rand_word();
    word_t w;
    w = {lcg_next(), lcg_next()};
    return w;
  endfunction

  // expected lookup result, taken from the model at the acknowledge edge
  task automatic predict_read(input idx_t idx, input off_t off, input tag_t tag);
    int bank;
    bank      = off[OFF_W-1 -: BANK_W];
    pend      = 1'b1;
    pend_vld  = ref_vld[idx];
    pend_hit  = '0;
    pend_data = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ref_vld[idx][w] && ref_tag[idx][w] == tag) begin
        pend_hit[w] = 1'b1;
        pend_data   = pend_data | ref_word[idx][w][bank];
      end
    end
  endtask

  task automatic apply_pending();
    chk_en   = pend;
    exp_hit  = pend_hit;
    exp_vld  = pend_vld;
    exp_data = pend_data;
    pend     = 1'b0;
  endtask

  task automatic merge_word(input int way, input idx_t idx, input off_t off,
                            input word_t data, input word_be_t be);
    int bank;
    bank = off[OFF_W-1 -: BANK_W];
    for (int b = 0; b < WORD_BE_W; b++) begin
      if (be[b]) begin
        ref_word[idx][way][bank][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // a read and a word write are requested alongside to see them blocked
  task automatic line_write(input idx_t idx, input way_mask_t way_we, input tag_t tag,
                            input way_mask_t vld_bits, input off_t off);
    line_t data;
    for (int k = 0; k < NUM_BANKS; k++) begin
      data[k*WORD_W +: WORD_W] = rand_word();
    end
    @(negedge clk_i);
    apply_pending();
    line_wr    = '{vld: 1'b1, way_we: way_we, tag: tag, idx: idx, off: off,
                   data: data, be: '1, vld_bits: vld_bits};
    exp_bypass = data[off[OFF_W-1 -: BANK_W]*WORD_W +: WORD_W];
    rd_req[0]  = '{idx: idx, off: off, req: 1'b1, prio: 1'b0};
    word_wr    = '{req: 2'b01, idx: idx, off: off, data: '0, be: '1};
    @(posedge clk_i);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_we[w]) begin
        ref_tag[idx][w]  = tag;
        ref_vld[idx][w]  = vld_bits[w];
        for (int k = 0; k < NUM_BANKS; k++) begin
          ref_word[idx][w][k] = data[k*WORD_W +: WORD_W];
        end
      end
    end
    @(negedge clk_i);
    line_wr.vld   = 1'b0;
    rd_req[0].req = 1'b0;
    word_wr.req   = '0;
  endtask

  task automatic read_line(input int port, input idx_t idx, input off_t off, input tag_t tag);
    @(negedge clk_i);
    apply_pending();
    rd_req[port] = '{idx: idx, off: off, req: 1'b1, prio: 1'b0};
    rd_tag[port] = tag;
    exp_rd_ack   = NUM_RD_PORTS'(1 << port);
    ack_chk      = 1'b1;
    #(CLK_PERIOD / 4);
    while (!rd_ack[port]) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
    end
    @(posedge clk_i);
    predict_read(idx, off, tag);
    rr_model = (port + 1) % NUM_RD_PORTS;
    @(negedge clk_i);
    rd_req[port].req = 1'b0;
    ack_chk          = 1'b0;
    apply_pending();
  endtask

  task automatic word_write(input int way, input idx_t idx, input off_t off,
                            input word_t data, input word_be_t be);
    @(negedge clk_i);
    apply_pending();
    word_wr    = '{req: way_mask_t'(1 << way), idx: idx, off: off, data: data, be: be};
    exp_wr_ack = 1'b1;
    wack_chk   = 1'b1;
    #(CLK_PERIOD / 4);
    while (!wr_ack) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
    end
    @(posedge clk_i);
    merge_word(way, idx, off, data, be);
    @(negedge clk_i);
    word_wr.req = '0;
    wack_chk    = 1'b0;
  endtask

  // both ports request every cycle, the grant follows priority then round robin
  task automatic arb_run(input logic p0, input logic p1, input int n,
                         input idx_t idx, input tag_t tag);
    logic [1:0] comp;
    int         g;
    off_t       off;
    for (int c = 0; c <= n; c++) begin
      @(negedge clk_i);
      apply_pending();
      if (c == n) begin
        rd_req[0].req = 1'b0;
        rd_req[1].req = 1'b0;
        ack_chk       = 1'b0;
      end else begin
        off       = off_t'((c % NUM_BANKS) << 3);
        rd_tag    = {tag, tag};
        rd_req[0] = '{idx: idx, off: off, req: 1'b1, prio: p0};
        rd_req[1] = '{idx: idx, off: off, req: 1'b1, prio: p1};
        comp       = (p0 | p1) ? {p1, p0} : 2'b11;
        g          = comp[rr_model] ? rr_model : 1 - rr_model;
        exp_rd_ack = NUM_RD_PORTS'(1 << g);
        ack_chk    = 1'b1;
        @(posedge clk_i);
        predict_read(idx, off, tag);
        rr_model = (g + 1) % NUM_RD_PORTS;
      end
    end
  endtask

  // port 0 reads while a word write goes to the same or another bank
  task automatic collide(input idx_t idx, input off_t rd_off, input off_t wr_off,
                         input tag_t tag, input word_t data);
    logic same;
    same = rd_off[OFF_W-1 -: BANK_W] == wr_off[OFF_W-1 -: BANK_W];
    @(negedge clk_i);
    apply_pending();
    rd_req[0]  = '{idx: idx, off: rd_off, req: 1'b1, prio: 1'b0};
    rd_tag[0]  = tag;
    word_wr    = '{req: 2'b10, idx: idx, off: wr_off, data: data, be: '1};
    exp_rd_ack = 2'b01;
    ack_chk    = 1'b1;
    exp_wr_ack = !same;
    wack_chk   = 1'b1;
    @(posedge clk_i);
    predict_read(idx, rd_off, tag);
    rr_model = 1;
    if (!same) begin
      merge_word(1, idx, wr_off, data, '1);
    end
    @(negedge clk_i);
    rd_req[0].req = 1'b0;
    ack_chk       = 1'b0;
    apply_pending();
    if (same) begin
      exp_wr_ack = 1'b1;
      @(posedge clk_i);
      merge_word(1, idx, wr_off, data, '1);
      @(negedge clk_i);
      apply_pending();
    end
    word_wr.req = '0;
    wack_chk    = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : p_watchdog
    #(NUM_STEPS * 20 * CLK_PERIOD);
    $display("timeout: the test sequence did not finish in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : p_main
    tag_t t;
    rst_ni   = 1'b0;
    rd_req   = '0;
    rd_tag   = '0;
    line_wr  = '0;
    word_wr  = '0;
    chk_en   = 1'b0;
    ack_chk  = 1'b0;
    wack_chk = 1'b0;
    pend     = 1'b0;
    rr_model = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // fill every set, way 1 gets a tag that differs from way 0
    for (int s = 0; s < NUM_SETS; s++) begin
      t = tag_t'(lcg_next());
      line_write(idx_t'(s), 2'b01, t, 2'b01, off_t'(lcg_next()));
      line_write(idx_t'(s), 2'b10, t ^ 8'h5a, 2'b10, off_t'(lcg_next()));
    end

    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int k = 0; k < NUM_BANKS; k++) begin
        read_line(k % 2, 4'd3, off_t'(k << 3), ref_tag[3][w]);
      end
    end
    read_line(0, 4'd3, 5'd8, ref_tag[3][0] ^ 8'h0f);
    line_write(4'd5, 2'b11, 8'h33, 2'b00, 5'd16);
    read_line(1, 4'd5, 5'd16, 8'h33);

    for (int i = 0; i < 4; i++) begin
      word_write(i % 2, 4'd7, off_t'(i << 3), rand_word(), word_be_t'(lcg_next()));
      read_line(0, 4'd7, off_t'(i << 3), ref_tag[7][i % 2]);
    end

    arb_run(1'b0, 1'b1, 2, 4'd9, ref_tag[9][1]);
    arb_run(1'b0, 1'b0, 4, 4'd9, ref_tag[9][0]);

    collide(4'd11, 5'd8, 5'd8, ref_tag[11][1], rand_word());
    collide(4'd11, 5'd8, 5'd24, ref_tag[11][1], rand_word());
    read_line(1, 4'd11, 5'd8, ref_tag[11][1]);
    read_line(0, 4'd11, 5'd24, ref_tag[11][1]);

    @(negedge clk_i);
    apply_pending();
    @(negedge clk_i);
    if (errors == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

// File: vlog.f
src/dcache_geom_pkg.sv
src/dcache_req_pkg.sv
src/dcache_sram.sv
src/dcache_port_arbiter.sv
src/dcache_tag_compare.sv
src/dcache_readout.sv
src/dcache_mem_top.sv
tb/tb_dcache_mem.sv
